//--- dv/fpmul32_tb.sv
`timescale 1ns/1ns

module fpmul32_tb import fpmul_pkg::*; ();

    localparam int MAX_WORDS = 256;                // room for 64 vectors of four words

    logic        clk;
    logic        rst_n;
    logic [31:0] a_i;
    logic [31:0] b_i;
    logic        start_i;
    logic        full_o;
    logic        done_o;
    logic [31:0] product_o;
    logic        nan_o;
    logic        infinite_o;
    logic        overflow_o;
    logic        underflow_o;

    logic [31:0] vec_mem [MAX_WORDS];              // a, b, product, flags per vector
    logic [99:0] expect_q [$];                     // {a, b, product, flags} in issue order
    logic        loaded = 1'b0;
    logic        full_q = 1'b0;                    // full_o seen at the last negedge
    logic        full_hit = 1'b0;
    int          num_vec = 0;
    int          issued_cnt = 0;
    int          done_cnt = 0;
    int          cycle_cnt = 0;                    // rising edges so far
    int          lat_start = -1;                   // edge that samples the first start
    int          value_errs = 0;
    int          flag_errs = 0;
    int          timing_errs = 0;
    int          other_errs = 0;

    fpmul32_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .a_i         (a_i),
        .b_i         (b_i),
        .start_i     (start_i),
        .full_o      (full_o),
        .done_o      (done_o),
        .product_o   (product_o),
        .nan_o       (nan_o),
        .infinite_o  (infinite_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                     // 8 ns period
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_and_finish();
        int total;
        total = value_errs + flag_errs + timing_errs + other_errs;
        $display("errors: value %0d, flags %0d, timing %0d, other %0d (results %0d of %0d)",
                 value_errs, flag_errs, timing_errs, other_errs, done_cnt, issued_cnt);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    // called on a rising edge, start is sampled on the next one
    task automatic issue_vector(input int idx);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] p;
        logic [31:0] f;
        a = vec_mem[4*idx];
        b = vec_mem[4*idx+1];
        p = vec_mem[4*idx+2];
        f = vec_mem[4*idx+3];
        a_i     <= a;
        b_i     <= b;
        start_i <= 1'b1;
        expect_q.push_back({a, b, p, f[3:0]});
        issued_cnt++;
    endtask

    task automatic check_result();
        logic [99:0] exp_v;
        logic [3:0]  got_flags;
        got_flags = {nan_o, infinite_o, overflow_o, underflow_o};
        if (done_cnt == 0) begin                   // first job ran on an idle design
            assert (cycle_cnt - lat_start == 5) else begin
                timing_errs++;
                $display("ERR %0t: first done_o %0d cycles after start, expected 5",
                         $time, cycle_cnt - lat_start);
            end
        end
        if (expect_q.size() == 0) begin
            other_errs++;
            $display("done_o pulsed at %0t although no result was outstanding", $time);
        end else begin
            exp_v = expect_q.pop_front();
            assert (product_o === exp_v[35:4]) else begin
                value_errs++;
                $display("ERR %0t: a=%08h b=%08h product expected %08h got %08h",
                         $time, exp_v[99:68], exp_v[67:36], exp_v[35:4], product_o);
            end
            assert (got_flags === exp_v[3:0]) else begin
                flag_errs++;
                $display("ERR %0t: a=%08h b=%08h flags expected %04b got %04b",
                         $time, exp_v[99:68], exp_v[67:36], exp_v[3:0], got_flags);
            end
        end
    endtask

    // outputs settle after the rising edge, so they are read here
    always @(negedge clk) begin
        full_q = full_o;
        if (full_o) begin
            full_hit = 1'b1;
            // four waiting in the FIFO plus one held by the core
            assert (issued_cnt - done_cnt == FIFO_DEPTH + 1) else begin
                timing_errs++;
                $display("ERR %0t: full_o high with %0d jobs outstanding, expected %0d",
                         $time, issued_cnt - done_cnt, FIFO_DEPTH + 1);
            end
        end
        if (done_o) begin
            check_result();
            done_cnt++;
        end
    end

    initial begin
        int          n;
        int          idx;
        int          wait_cnt;
        logic [31:0] rng;
        rst_n   <= 1'b0;
        a_i     <= '0;
        b_i     <= '0;
        start_i <= 1'b0;
        rng      = 32'd67;                         // fixed seed
        n        = 0;
        idx      = 0;
        wait_cnt = 0;
        $readmemh("dv/fpmul32_testdata.txt", vec_mem);
        while (n < MAX_WORDS && !$isunknown(vec_mem[n])) begin
            n++;
        end
        num_vec = n / 4;
        loaded  = 1'b1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!done_o && !full_o && !nan_o && !infinite_o && !overflow_o && !underflow_o)
        else begin
            flag_errs++;
            $display("ERR %0t: done, full or a flag not low after reset", $time);
        end
        if (num_vec == 0) begin
            other_errs++;
            $display("no vectors could be read from dv/fpmul32_testdata.txt");
        end else begin
            while (idx < num_vec) begin
                @(posedge clk);
                start_i <= 1'b0;                   // overridden below when a start goes out
                if (wait_cnt > 0) begin
                    wait_cnt--;
                end else if (!full_q && (issued_cnt - done_cnt < FIFO_DEPTH + 1)) begin
                    if (idx == 0) begin
                        lat_start = cycle_cnt + 2; // sampling edge, one after this one
                    end
                    issue_vector(idx);
                    idx++;
                    rng = xorshift32(rng);
                    // random gaps first, then one back-to-back burst
                    wait_cnt = (idx < num_vec / 2) ? int'(rng % 7) : 0;
                end
            end
            @(posedge clk);
            start_i <= 1'b0;
            wait (done_cnt == issued_cnt);
            repeat (10) @(posedge clk);            // catch any stray done pulse
            assert (full_hit) else begin
                other_errs++;
                $display("full_o never rose during the back-to-back burst");
            end
            assert (issued_cnt == num_vec && done_cnt == issued_cnt) else begin
                other_errs++;
                $display("start and done counts differ: %0d starts, %0d results",
                         issued_cnt, done_cnt);
            end
        end
        report_and_finish();
    end

    // watchdog, about 20 cycles per vector plus a margin
    initial begin
        wait (loaded);
        repeat (num_vec * 20 + 100) @(posedge clk);
        other_errs++;
        $display("timeout: the results never all arrived, %0d of %0d came back",
                 done_cnt, issued_cnt);
        report_and_finish();
    end

endmodule

//--- dv/fpmul32_testdata.txt
// columns: a  b  expected_product  expected_flags, all hex
// flags bits: 3 nan, 2 infinite, 1 overflow, 0 underflow
3F800000 3F800000 3F800000 0
40000000 40400000 40C00000 0
3FC00000 3FC00000 40100000 0
C0400000 40800000 C1400000 0
40490FDB 3F800000 40490FDB 0
3F800001 3FC00000 3FC00002 0
3F800003 3FC00000 3FC00004 0
3FFFFFFF 3F800001 40000000 0
3FFFFFFE 3F800001 40000000 0
42F60000 C2C80000 C6403000 0
3DCCCCCD 41200000 3F800000 0
3DCCCCCD 3DCCCCCD 3C23D70B 0
7FC00000 3F800000 7FC00000 8
7F800001 40000000 7FC00000 8
FFC00000 7F800000 7FC00000 8
7F800000 00000000 7FC00000 8
80000000 FF800000 7FC00000 8
7F800000 40000000 7F800000 4
7F800000 BF800000 FF800000 4
FF800000 FF800000 7F800000 4
80000000 3F800000 80000000 0
00400000 40000000 00000000 0
807FFFFF 3F800000 80000000 0
7F000000 40000000 7F800000 2
7F7FFFFF 7F7FFFFF 7F800000 2
7F7FFFFF 3F800001 7F800000 2
7F000000 3F800000 7F000000 0
00800000 3F000000 00000000 1
80800000 3F000000 80000000 1
00800000 00800000 00000000 1
1E000000 80800000 80000000 1

//--- fpmul32.f
rtl/fpmul_pkg.sv
rtl/fp_operand_unpack.sv
rtl/fp_op_fifo.sv
rtl/fp_mult_core.sv
rtl/fpmul32_top.sv
dv/fpmul32_tb.sv

//--- rtl/fp_mult_core.sv
`timescale 1ns/1ns

module fp_mult_core import fpmul_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             empty_i,
    input  logic [JOB_W-1:0] job_i,                // FIFO head word
    output logic             pop_o,
    output logic             done_o,               // one-cycle pulse per result
    output logic [31:0]      product_o,
    output logic             nan_o,
    output logic             infinite_o,
    output logic             overflow_o,
    output logic             underflow_o
);

    logic [1:0]               state_q;
    logic                     job_sign_q;          // captured job fields
    logic [1:0]               job_cls_q;
    logic signed [XEXP_W-1:0] job_exp_q;
    logic [SIG_W-1:0]         sig_a_q;
    logic [SIG_W-1:0]         sig_b_q;
    logic [2*SIG_W-1:0]       prod_q;              // 48-bit significand product
    logic [SIG_W-1:0]         norm_sig;
    logic signed [XEXP_W-1:0] norm_exp;
    logic                     guard;
    logic                     sticky;
    logic                     round_up;
    logic [SIG_W:0]           rnd_sum;             // extra bit catches round carry
    logic signed [XEXP_W-1:0] rnd_exp;
    logic [FRAC_W-1:0]        rnd_frac;
    logic signed [XEXP_W-1:0] rnd_exp_q;
    logic [FRAC_W-1:0]        rnd_frac_q;
    fp32_u                    res;                 // packed result
    logic                     res_nan;
    logic                     res_inf;
    logic                     res_ovf;
    logic                     res_unf;

    assign pop_o = (state_q == ST_IDLE) && !empty_i;  // head taken on this edge

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: if (pop_o) state_q <= ST_MUL;
                ST_MUL:  state_q <= ST_NORM;
                ST_NORM: state_q <= ST_PACK;
                default: state_q <= ST_IDLE;       // pack done, ready again
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            {job_sign_q, job_cls_q, job_exp_q, sig_a_q, sig_b_q} <= job_i;
        end
        if (state_q == ST_MUL) begin
            prod_q <= sig_a_q * sig_b_q;           // 1.x times 1.x, below 4.0
        end
        if (state_q == ST_NORM) begin
            rnd_exp_q  <= rnd_exp;
            rnd_frac_q <= rnd_frac;
        end
    end

    // normalize then round to nearest, ties to even
    always_comb begin
        if (prod_q[2*SIG_W-1]) begin               // product at or above 2.0
            norm_sig = prod_q[2*SIG_W-1 -: SIG_W];
            guard    = prod_q[SIG_W-1];
            sticky   = |prod_q[SIG_W-2:0];
            norm_exp = job_exp_q + XEXP_W'(1);     // shifted right once
        end else begin
            norm_sig = prod_q[2*SIG_W-2 -: SIG_W];
            guard    = prod_q[SIG_W-2];
            sticky   = |prod_q[SIG_W-3:0];
            norm_exp = job_exp_q;
        end
        round_up = guard && (sticky || norm_sig[0]);  // lsb breaks the tie
        rnd_sum  = {1'b0, norm_sig} + (SIG_W + 1)'(round_up);
        if (rnd_sum[SIG_W]) begin                  // all ones rolled over
            rnd_frac = rnd_sum[SIG_W-1:1];
            rnd_exp  = norm_exp + XEXP_W'(1);
        end else begin
            rnd_frac = rnd_sum[FRAC_W-1:0];        // hidden bit dropped
            rnd_exp  = norm_exp;
        end
    end

    always_comb begin
        res.word   = '0;
        res.f.sign = job_sign_q;
        res_nan    = 1'b0;
        res_inf    = 1'b0;
        res_ovf    = 1'b0;
        res_unf    = 1'b0;
        case (job_cls_q)
            CLS_NAN: begin
                res.word = QNAN_WORD;              // sign not kept for nan
                res_nan  = 1'b1;
            end
            CLS_INF: begin
                res.f.exp = '1;
                res_inf   = 1'b1;
            end
            CLS_NORMAL: begin
                if (rnd_exp_q >= EXP_MAX) begin
                    res.f.exp = '1;                // signed infinity
                    res_ovf   = 1'b1;
                end else if (rnd_exp_q <= 0) begin
                    res_unf = 1'b1;                // flushed to signed zero
                end else begin
                    res.f.exp  = rnd_exp_q[EXP_W-1:0];
                    res.f.frac = rnd_frac_q;
                end
            end
            default: ;                             // zero class, signed zero from above
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_o      <= 1'b0;
            product_o   <= '0;
            nan_o       <= 1'b0;
            infinite_o  <= 1'b0;
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
        end else begin
            done_o <= (state_q == ST_PACK);
            if (state_q == ST_PACK) begin          // held until the next done
                product_o   <= res.word;
                nan_o       <= res_nan;
                infinite_o  <= res_inf;
                overflow_o  <= res_ovf;
                underflow_o <= res_unf;
            end
        end
    end

endmodule

//--- rtl/fp_op_fifo.sv
`timescale 1ns/1ns

module fp_op_fifo import fpmul_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push_i,
    input  logic [JOB_W-1:0] wr_job_i,
    input  logic             pop_i,
    output logic [JOB_W-1:0] rd_job_o,             // head word
    output logic             empty_o,
    output logic             full_o
);

    logic [JOB_W-1:0]   mem [FIFO_DEPTH];          // job storage
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;                     // occupancy, 0..FIFO_DEPTH
    logic               do_push;
    logic               do_pop;

    assign empty_o = (count == '0);
    assign full_o  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));

    assign do_push = push_i && !full_o;            // push on full is dropped
    assign do_pop  = pop_i && !empty_o;            // pop on empty is ignored

    assign rd_job_o = mem[rd_ptr];                 // head visible without a pop

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_job_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;           // wraps at FIFO_DEPTH
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // both or neither
            endcase
        end
    end

endmodule

//--- rtl/fp_operand_unpack.sv
`timescale 1ns/1ns

module fp_operand_unpack import fpmul_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [31:0]      a_i,
    input  logic [31:0]      b_i,
    input  logic             start_i,
    input  logic             fifo_full_i,          // back-pressure from the buffer
    output logic             push_o,               // one-cycle strobe
    output logic [JOB_W-1:0] job_o
);

    fp32_u                    op_a;                // field view of a_i
    fp32_u                    op_b;                // field view of b_i
    logic                     a_zero;
    logic                     b_zero;
    logic                     a_inf;
    logic                     b_inf;
    logic                     a_nan;
    logic                     b_nan;
    logic                     sign_x;              // product sign
    logic [1:0]               cls;
    logic signed [XEXP_W-1:0] exp_sum;
    logic [SIG_W-1:0]         sig_a;
    logic [SIG_W-1:0]         sig_b;
    logic                     accept;

    assign op_a.word = a_i;
    assign op_b.word = b_i;

    // zero exponent covers true zero and flushed subnormals
    assign a_zero = (op_a.f.exp == '0);
    assign b_zero = (op_b.f.exp == '0);
    assign a_inf  = (op_a.f.exp == EXP_MAX) && (op_a.f.frac == '0);
    assign b_inf  = (op_b.f.exp == EXP_MAX) && (op_b.f.frac == '0);
    assign a_nan  = (op_a.f.exp == EXP_MAX) && (op_a.f.frac != '0);
    assign b_nan  = (op_b.f.exp == EXP_MAX) && (op_b.f.frac != '0);

    assign sign_x = op_a.f.sign ^ op_b.f.sign;     // xor of operand signs

    // class priority: nan, then inf, then zero, then normal
    always_comb begin
        if (a_nan || b_nan || (a_inf && b_zero) || (b_inf && a_zero)) begin
            cls = CLS_NAN;                         // nan in, or inf times zero
        end else if (a_inf || b_inf) begin
            cls = CLS_INF;
        end else if (a_zero || b_zero) begin
            cls = CLS_ZERO;
        end else begin
            cls = CLS_NORMAL;
        end
    end

    // ea + eb - bias, kept signed so the core can see under and overflow
    assign exp_sum = $signed({{(XEXP_W-EXP_W){1'b0}}, op_a.f.exp})
                   + $signed({{(XEXP_W-EXP_W){1'b0}}, op_b.f.exp})
                   - XEXP_W'(EXP_BIAS);

    assign sig_a = {1'b1, op_a.f.frac};            // hidden bit attached
    assign sig_b = {1'b1, op_b.f.frac};

    assign accept = start_i && !fifo_full_i;       // start dropped while full

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push_o <= 1'b0;
        end else begin
            push_o <= accept;                      // push one edge after start
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (cls == CLS_NORMAL) begin
                job_o <= {sign_x, cls, exp_sum, sig_a, sig_b};
            end else begin
                job_o <= {sign_x, cls, {(XEXP_W + 2 * SIG_W){1'b0}}};  // no payload needed
            end
        end
    end

endmodule

//--- rtl/fpmul32_top.sv
`timescale 1ns/1ns

module fpmul32_top import fpmul_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    input  logic        start_i,
    output logic        full_o,                    // caller holds start while high
    output logic        done_o,
    output logic [31:0] product_o,
    output logic        nan_o,
    output logic        infinite_o,
    output logic        overflow_o,
    output logic        underflow_o
);

    logic             push;                        // unpacker to FIFO
    logic [JOB_W-1:0] job;
    logic             pop;                         // core to FIFO
    logic             empty;
    logic [JOB_W-1:0] rd_job;

    fp_operand_unpack u_unpack (
        .clk         (clk),
        .rst_n       (rst_n),
        .a_i         (a_i),
        .b_i         (b_i),
        .start_i     (start_i),
        .fifo_full_i (full_o),
        .push_o      (push),
        .job_o       (job)
    );

    fp_op_fifo u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push_i   (push),
        .wr_job_i (job),
        .pop_i    (pop),
        .rd_job_o (rd_job),
        .empty_o  (empty),
        .full_o   (full_o)                         // also the outside back-pressure
    );

    fp_mult_core u_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .empty_i     (empty),
        .job_i       (rd_job),
        .pop_o       (pop),
        .done_o      (done_o),
        .product_o   (product_o),
        .nan_o       (nan_o),
        .infinite_o  (infinite_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o)
    );

endmodule

//--- rtl/fpmul_pkg.sv
package fpmul_pkg;

    localparam int EXP_W    = 8;                    // biased exponent field
    localparam int FRAC_W   = 23;                   // stored fraction field
    localparam int SIG_W    = 24;                   // significand with hidden bit
    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 255;                  // reserved for inf and nan
    localparam int XEXP_W   = 10;                   // signed working exponent

    // result class, decided by the unpacker and obeyed by the core
    localparam logic [1:0] CLS_NORMAL = 2'd0;
    localparam logic [1:0] CLS_ZERO   = 2'd1;
    localparam logic [1:0] CLS_INF    = 2'd2;
    localparam logic [1:0] CLS_NAN    = 2'd3;

    localparam logic [31:0] QNAN_WORD = 32'h7FC0_0000;  // canonical quiet nan

    // job word: sign, class, exponent sum, significand a, significand b
    localparam int JOB_W = 1 + 2 + XEXP_W + 2 * SIG_W;

    localparam int FIFO_DEPTH = 4;                  // jobs waiting ahead of the core
    localparam int FIFO_AW    = 2;                  // pointer width for FIFO_DEPTH

    // multiply core FSM
    localparam logic [1:0] ST_IDLE = 2'd0;          // waiting for a job
    localparam logic [1:0] ST_MUL  = 2'd1;          // significand product
    localparam logic [1:0] ST_NORM = 2'd2;          // normalize and round
    localparam logic [1:0] ST_PACK = 2'd3;          // pack result and flags

    // one word seen either raw or as ieee fields
    typedef union packed {
        logic [31:0] word;                          // raw bit pattern
        struct packed {
            logic              sign;
            logic [EXP_W-1:0]  exp;
            logic [FRAC_W-1:0] frac;
        } f;
    } fp32_u;

endpackage
